/* dv/gpio_subsys_tb.sv */
/* GPIO subsystem testbench
   Bus and pin stimulus, register reference model, concurrent output checks */
`timescale 1ns/10ps

module gpio_subsys_tb;

  localparam int NUM_PORTS  = 2;
  localparam int MAX_CYCLES = 3000;  // About ten times the stimulus length

  // Register addresses inside one port
  localparam logic [31:0] DIR_ADDR  = {21'd0, iop_pkg::DIR_OFFSET, 4'h0};
  localparam logic [31:0] MASK_ADDR = {21'd0, iop_pkg::INTMASK_OFFSET, 4'h0};

  logic                      FCLK;
  logic                      HRESETn;
  logic                      io_sel;
  logic [31:0]               io_addr;
  logic                      io_write;
  iop_pkg::io_size_e         io_size;
  logic                      io_trans;
  logic [31:0]               io_wdata;
  logic [31:0]               io_rdata;
  logic [NUM_PORTS*32-1:0]   gpio_in;
  logic [NUM_PORTS*32-1:0]   gpio_out;
  logic [NUM_PORTS*32-1:0]   gpio_en;
  logic [NUM_PORTS-1:0]      gpio_int;

  int                        errors      = 0;
  int                        cycle_count = 0;
  logic [31:0]               lcg_state   = 32'h95f5_d5e9;

  tb_clk_gen u_clk_gen (
    .FCLK    (FCLK),
    .HRESETn (HRESETn)
  );

  gpio_subsys #(
    .NUM_PORTS (NUM_PORTS)
  ) uut (
    .FCLK       (FCLK),
    .HRESETn    (HRESETn),
    .io_sel_i   (io_sel),
    .io_addr_i  (io_addr),
    .io_write_i (io_write),
    .io_size_i  (io_size),
    .io_trans_i (io_trans),
    .io_wdata_i (io_wdata),
    .io_rdata_o (io_rdata),
    .gpio_in_i  (gpio_in),
    .gpio_out_o (gpio_out),
    .gpio_en_o  (gpio_en),
    .gpio_int_o (gpio_int)
  );

  // --------------------------------------------------
  // Rule helpers
  // --------------------------------------------------

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper LCG bits as the low ones repeat too quickly
  function automatic iop_pkg::io_size_e pick_size();
    case ((next_rand() >> 16) % 3)
      0:       return iop_pkg::SIZE_BYTE;
      1:       return iop_pkg::SIZE_HALF;
      default: return iop_pkg::SIZE_WORD;
    endcase
  endfunction

  function automatic logic [31:0] port_base(int unsigned p);
    return p << iop_pkg::PORT_SPAN_BITS;
  endfunction

  // Full bytes touched by an access
  function automatic logic [31:0] lanes_of(iop_pkg::io_size_e size, logic [31:0] addr);
    logic [31:0] m;
    m = '0;
    for (int b = 0; b < 4; b++)
    begin
      if (size == iop_pkg::SIZE_WORD)
        m[b*8 +: 8] = 8'hff;
      else if (size == iop_pkg::SIZE_HALF && (b / 2) == addr[1])
        m[b*8 +: 8] = 8'hff;
      else if (size == iop_pkg::SIZE_BYTE && b == addr[1:0])
        m[b*8 +: 8] = 8'hff;
    end
    return m;
  endfunction

  // Byte access narrows the lane to the address bit mask
  function automatic logic [31:0] bits_of(iop_pkg::io_size_e size, logic [31:0] addr);
    if (size != iop_pkg::SIZE_BYTE)
      return lanes_of(size, addr);
    return {24'd0, addr[9:2]} << (addr[1:0] * 8);
  endfunction

  function automatic iop_pkg::gpio_reg_e target_of(logic [31:0] addr);
    if (!addr[10])
      return iop_pkg::REG_DATA;
    if (addr[10:4] == iop_pkg::DIR_OFFSET)
      return iop_pkg::REG_DIR;
    if (addr[10:4] == iop_pkg::INTMASK_OFFSET)
      return iop_pkg::REG_INTMASK;
    return iop_pkg::REG_NONE;
  endfunction

  function automatic logic [31:0] merge(logic [31:0] old, logic [31:0] wdata, logic [31:0] m);
    return (wdata & m) | (old & ~m);
  endfunction

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  logic [31:0]              m_out    [NUM_PORTS];  // Data out
  logic [31:0]              m_dir    [NUM_PORTS];  // Direction
  logic [31:0]              m_mask   [NUM_PORTS];  // Interrupt mask
  logic [31:0]              m_sample [NUM_PORTS];  // Pins before the last edge
  logic [NUM_PORTS-1:0]     m_int;
  logic [20:0]              acc_idx;               // Port index from the address
  logic                     wr_hit;
  logic [31:0]              exp_rdata;
  logic [NUM_PORTS*32-1:0]  exp_out;
  logic [NUM_PORTS*32-1:0]  exp_en;

  assign acc_idx = io_addr[31:iop_pkg::PORT_SPAN_BITS];
  assign wr_hit  = io_sel & io_write & io_trans & (acc_idx < NUM_PORTS);

  always @(posedge FCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        m_out[p]    <= '0;
        m_dir[p]    <= '0;
        m_mask[p]   <= '0;
        m_sample[p] <= '0;
      end
      m_int <= '0;
    end
    else
    begin
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        m_sample[p] <= gpio_in[p*32 +: 32];
        // Pulse on any enabled input that moved
        m_int[p] <= |((m_sample[p] ^ gpio_in[p*32 +: 32]) & m_mask[p] & ~m_dir[p]);
      end
      if (wr_hit)
      begin
        case (target_of(io_addr))
          iop_pkg::REG_DATA:
            m_out[acc_idx] <= merge(m_out[acc_idx], io_wdata, bits_of(io_size, io_addr));
          iop_pkg::REG_DIR:
            m_dir[acc_idx] <= merge(m_dir[acc_idx], io_wdata, lanes_of(io_size, io_addr));
          iop_pkg::REG_INTMASK:
            m_mask[acc_idx] <= merge(m_mask[acc_idx], io_wdata, lanes_of(io_size, io_addr));
          default:
            ;  // Unmapped offset
        endcase
      end
    end
  end

  // Read data of the current cycle
  always_comb
  begin
    exp_rdata = '0;
    if (io_sel && acc_idx < NUM_PORTS)
    begin
      case (target_of(io_addr))
        iop_pkg::REG_DATA:    exp_rdata = m_sample[acc_idx];  // Sampled pins
        iop_pkg::REG_DIR:     exp_rdata = m_dir[acc_idx];
        iop_pkg::REG_INTMASK: exp_rdata = m_mask[acc_idx];
        default:              exp_rdata = '0;
      endcase
      exp_rdata = exp_rdata & bits_of(io_size, io_addr);
    end
  end

  always_comb
  begin
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      exp_out[p*32 +: 32] = m_out[p];
      exp_en[p*32 +: 32]  = m_dir[p];
    end
  end

  // --------------------------------------------------
  // Checks and run control
  // --------------------------------------------------

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1, "Simulation stopped on failure");
  endtask

  task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
    errors++;
    $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
    abort_run();
  endtask

  a_rdata: assert property (@(posedge FCLK) disable iff (!HRESETn) io_rdata == exp_rdata)
    else report_mismatch("io_rdata_o", $sampled(exp_rdata), $sampled(io_rdata));
  a_out: assert property (@(posedge FCLK) disable iff (!HRESETn) gpio_out == exp_out)
    else report_mismatch("gpio_out_o", $sampled(exp_out), $sampled(gpio_out));
  a_en: assert property (@(posedge FCLK) disable iff (!HRESETn) gpio_en == exp_en)
    else report_mismatch("gpio_en_o", $sampled(exp_en), $sampled(gpio_en));
  a_int: assert property (@(posedge FCLK) disable iff (!HRESETn) gpio_int == m_int)
    else report_mismatch("gpio_int_o", $sampled(m_int), $sampled(gpio_int));

  always @(posedge FCLK)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("Timeout: stimulus still running after %0d cycles", MAX_CYCLES);
      abort_run();
    end
  end

  // --------------------------------------------------
  // Bus and pin stimulus
  // --------------------------------------------------

  // One cycle on the bus driven at the falling edge
  task automatic bus_access(logic sel, logic trans, logic wr, iop_pkg::io_size_e size,
                            logic [31:0] addr, logic [31:0] wdata);
    @(negedge FCLK);
    io_sel   = sel;
    io_trans = trans;
    io_write = wr;
    io_size  = size;
    io_addr  = addr;
    io_wdata = wdata;
  endtask

  task automatic write_reg(iop_pkg::io_size_e size, logic [31:0] addr, logic [31:0] wdata);
    bus_access(1'b1, 1'b1, 1'b1, size, addr, wdata);
  endtask

  task automatic read_reg(iop_pkg::io_size_e size, logic [31:0] addr);
    bus_access(1'b1, 1'b1, 1'b0, size, addr, next_rand());  // Write data ignored
  endtask

  task automatic bus_idle(int cycles);
    repeat (cycles)
    begin
      @(negedge FCLK);
      io_sel   = 1'b0;
      io_trans = 1'b0;
      io_write = 1'b0;
    end
  endtask

  // Flip one pin then hold the pins still
  task automatic flip_pin(int p, int b);
    bus_idle(1);
    gpio_in[p*32 + b] = ~gpio_in[p*32 + b];
    bus_idle(3);
  endtask

  initial
  begin
    logic [31:0] addr;
    iop_pkg::io_size_e size;

    io_sel   = 1'b0;
    io_addr  = '0;
    io_write = 1'b0;
    io_size  = iop_pkg::SIZE_WORD;
    io_trans = 1'b0;
    io_wdata = '0;
    gpio_in  = '0;
    @(posedge HRESETn);
    bus_idle(2);

    // Reset values of both ports
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      read_reg(iop_pkg::SIZE_WORD, port_base(p) | DIR_ADDR);
      read_reg(iop_pkg::SIZE_WORD, port_base(p) | MASK_ADDR);
    end

    // Direction and mask writes with random size and lane
    repeat (40)
    begin
      addr = port_base((next_rand() >> 20) % NUM_PORTS) | (next_rand() & 32'hf);
      addr = addr | (((next_rand() >> 24) % 2) ? MASK_ADDR : DIR_ADDR);
      size = pick_size();
      write_reg(size, addr, next_rand());
      read_reg(size, addr);
      read_reg(iop_pkg::SIZE_WORD, addr);
    end

    // Data out with a word write first and masked writes after
    for (int p = 0; p < NUM_PORTS; p++)
      write_reg(iop_pkg::SIZE_WORD, port_base(p), next_rand());
    repeat (30)
    begin
      addr = port_base((next_rand() >> 20) % NUM_PORTS) | (next_rand() & 32'h3ff);
      write_reg(pick_size(), addr, next_rand());
    end

    // Data reads while the pins move in the same cycle
    repeat (30)
    begin
      addr = port_base((next_rand() >> 20) % NUM_PORTS) | (next_rand() & 32'h3ff);
      read_reg(pick_size(), addr);
      gpio_in = {next_rand(), next_rand()};
    end

    // Change interrupt with the upper half of port 0 driving
    bus_idle(1);
    gpio_in = '0;
    write_reg(iop_pkg::SIZE_WORD, port_base(0) | DIR_ADDR, 32'hffff_0000);
    write_reg(iop_pkg::SIZE_WORD, port_base(0) | MASK_ADDR, 32'h0f0f_0f0f);
    write_reg(iop_pkg::SIZE_WORD, port_base(1) | DIR_ADDR, 32'h0);
    write_reg(iop_pkg::SIZE_WORD, port_base(1) | MASK_ADDR, 32'h0);
    bus_idle(3);
    flip_pin(0, 3);   // Masked input
    flip_pin(0, 5);   // Unmasked input
    flip_pin(0, 17);  // Masked output bit
    flip_pin(0, 8);   // Masked input in byte 1
    flip_pin(1, 3);   // Port 1 has no mask
    write_reg(iop_pkg::SIZE_WORD, port_base(1) | MASK_ADDR, 32'hffff_ffff);
    flip_pin(1, 20);
    flip_pin(0, 20);  // Port 0 output bit

    // Port independence and unmapped accesses
    write_reg(iop_pkg::SIZE_WORD, port_base(1), next_rand());
    write_reg(iop_pkg::SIZE_WORD, port_base(1) | DIR_ADDR, next_rand());
    for (int p = NUM_PORTS; p < 4; p++)
    begin
      write_reg(iop_pkg::SIZE_WORD, port_base(p), next_rand());
      write_reg(iop_pkg::SIZE_WORD, port_base(p) | DIR_ADDR, next_rand());
      read_reg(iop_pkg::SIZE_WORD, port_base(p) | DIR_ADDR);
      read_reg(iop_pkg::SIZE_WORD, port_base(p));
    end
    write_reg(iop_pkg::SIZE_WORD, port_base(0) | 32'h420, next_rand());  // REG_NONE
    read_reg(iop_pkg::SIZE_WORD, port_base(0) | 32'h420);
    bus_access(1'b0, 1'b1, 1'b1, iop_pkg::SIZE_WORD, port_base(0),
               next_rand());  // Not selected
    bus_access(1'b1, 1'b0, 1'b1, iop_pkg::SIZE_WORD, port_base(0),
               next_rand());  // Selected write without a transaction
    read_reg(iop_pkg::SIZE_WORD, port_base(0) | DIR_ADDR);
    read_reg(iop_pkg::SIZE_WORD, port_base(1) | DIR_ADDR);
    bus_idle(4);

    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

/* dv/tb_clk_gen.sv */
/* Testbench clock and reset
   100 ns FCLK, HRESETn held low for the first 16 cycles */
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int HALF_PERIOD  = 50,  // ns, full period 100 ns
  parameter int RESET_CYCLES = 16
) (
  output logic FCLK,     // Free running clock
  output logic HRESETn   // Active low reset
);

  initial
  begin
    FCLK = 1'b0;
    forever
      #HALF_PERIOD FCLK = ~FCLK;
  end

  initial
  begin
    HRESETn = 1'b0;
    repeat (RESET_CYCLES) @(posedge FCLK);
    @(negedge FCLK);
    HRESETn = 1'b1;      // Release away from the active edge
  end

endmodule

/* gpio_subsys.f */
source/iop_pkg.sv
source/iop_bus_if.sv
source/gpio_byte_mask.sv
source/gpio_port.sv
source/iop_decoder.sv
source/gpio_subsys.sv
dv/tb_clk_gen.sv
dv/gpio_subsys_tb.sv

/* source/gpio_byte_mask.sv */
/* GPIO byte lane mask
   Lane mask from size and low address, plus the bit mask for masked data-out access */
`timescale 1ns/10ps

module gpio_byte_mask (
  input  iop_pkg::io_size_e size_i,       // Transfer size
  input  logic [9:0]        addr_i,       // Low address bits of the access
  output logic [31:0]       lane_mask_o,  // All bits of the accessed lanes
  output logic [31:0]       data_mask_o   // Lane mask, or bit mask on byte access
);

  logic [3:0] lane_en;   // One enable per byte lane
  logic [7:0] bit_mask;  // Per-bit mask carried in the address

  // --------------------------------------------------
  // Byte lane decode
  // --------------------------------------------------

  always_comb
  begin
    case (size_i)
      iop_pkg::SIZE_BYTE:
        lane_en = 4'b0001 << addr_i[1:0];              // Single lane
      iop_pkg::SIZE_HALF:
        lane_en = addr_i[1] ? 4'b1100 : 4'b0011;       // Aligned lane pair
      default:
        lane_en = 4'b1111;                             // Word, all lanes
    endcase
  end

  // Expand each lane enable to eight bits
  assign lane_mask_o = {
    {8{lane_en[3]}},
    {8{lane_en[2]}},
    {8{lane_en[1]}},
    {8{lane_en[0]}}
  };

  // --------------------------------------------------
  // Masked data lane
  // --------------------------------------------------

  // On byte access, address bits 9:2 pick the bits inside the lane
  assign bit_mask = addr_i[9:2];

  always_comb
  begin
    if (size_i == iop_pkg::SIZE_BYTE)
      data_mask_o = {4{bit_mask}} & lane_mask_o;  // Only the addressed lane survives
    else
      data_mask_o = lane_mask_o;                  // Half-word and word use full lanes
  end

endmodule

/* source/gpio_port.sv */
/* GPIO port
   32-bit data-out, direction and interrupt mask registers, input sampler and change interrupt */
`timescale 1ns/10ps

module gpio_port (
  input  logic        FCLK,        // Port clock
  input  logic        HRESETn,     // Async reset, active low
  iop_bus_if.slave    bus,         // Decoded bus leg
  input  logic [31:0] gpio_in_i,   // Pad inputs
  output logic [31:0] gpio_out_o,  // Pad outputs
  output logic [31:0] gpio_en_o,   // Pad output enables
  output logic        gpio_int_o   // Input change pulse
);

  logic [31:0]        lane_mask;   // Accessed byte lanes
  logic [31:0]        data_mask;   // Lanes, or bit mask on byte access
  iop_pkg::gpio_reg_e reg_sel;     // Decoded register target
  logic               wr_en;       // Qualified write this cycle

  logic [31:0]        data_out_q;  // Data out register
  logic [31:0]        dir_q;       // Direction register
  logic [31:0]        intmask_q;   // Interrupt mask register
  logic [31:0]        data_in_q;   // Pin sample from the last edge
  logic [31:0]        changed;     // Enabled input bits that moved
  logic               int_q;       // Registered change pulse
  logic [31:0]        rd_val;      // Unmasked read value

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------

  gpio_byte_mask u_byte_mask (
    .size_i      (bus.size),
    .addr_i      (bus.addr[9:0]),
    .lane_mask_o (lane_mask),
    .data_mask_o (data_mask)
  );

  always_comb
  begin
    if (!bus.addr[10])
      reg_sel = iop_pkg::REG_DATA;      // Whole lower half is data
    else if (bus.addr[10:4] == iop_pkg::DIR_OFFSET)
      reg_sel = iop_pkg::REG_DIR;
    else if (bus.addr[10:4] == iop_pkg::INTMASK_OFFSET)
      reg_sel = iop_pkg::REG_INTMASK;
    else
      reg_sel = iop_pkg::REG_NONE;      // Reads zero, writes ignored
  end

  assign wr_en = bus.sel & bus.write & bus.trans;

  // --------------------------------------------------
  // Register writes
  // --------------------------------------------------

  always_ff @(posedge FCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      data_out_q <= '0;
      dir_q      <= '0;   // All pins inputs out of reset
      intmask_q  <= '0;
    end
    else if (wr_en)
    begin
      case (reg_sel)
        // Data out merges under the per-bit data mask
        iop_pkg::REG_DATA:
          data_out_q <= (bus.wdata & data_mask) | (data_out_q & ~data_mask);
        iop_pkg::REG_DIR:
          dir_q <= (bus.wdata & lane_mask) | (dir_q & ~lane_mask);
        iop_pkg::REG_INTMASK:
          intmask_q <= (bus.wdata & lane_mask) | (intmask_q & ~lane_mask);
        default:
          ;                                   // Unmapped, nothing changes
      endcase
    end
  end

  // --------------------------------------------------
  // Input sampler and change interrupt
  // --------------------------------------------------

  // Compare live pins with last sample, only masked input bits count
  assign changed = (data_in_q ^ gpio_in_i) & intmask_q & ~dir_q;

  always_ff @(posedge FCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      data_in_q <= '0;
      int_q     <= 1'b0;
    end
    else
    begin
      data_in_q <= gpio_in_i;   // Sample every edge
      int_q     <= |changed;    // High one cycle per change
    end
  end

  assign gpio_out_o = data_out_q;
  assign gpio_en_o  = dir_q;
  assign gpio_int_o = int_q;

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------

  always_comb
  begin
    case (reg_sel)
      iop_pkg::REG_DATA:    rd_val = data_in_q;   // Sampled pins, not data out
      iop_pkg::REG_DIR:     rd_val = dir_q;
      iop_pkg::REG_INTMASK: rd_val = intmask_q;
      default:              rd_val = '0;
    endcase
  end

  // Lanes outside the access read zero
  assign bus.rdata = rd_val & data_mask;

endmodule

/* source/gpio_subsys.sv */
/* GPIO subsystem top
   Address decoder and NUM_PORTS GPIO ports on one I/O port bus */
`timescale 1ns/10ps

module gpio_subsys #(
  parameter int NUM_PORTS = 2
) (
  input  logic                   FCLK,        // Bus and sampling clock
  input  logic                   HRESETn,     // Async reset, active low

  // --------------------------------------------------
  // I/O port bus
  // --------------------------------------------------
  input  logic                   io_sel_i,    // Subsystem select
  input  logic [31:0]            io_addr_i,   // Transfer address
  input  logic                   io_write_i,  // Transfer direction
  input  iop_pkg::io_size_e      io_size_i,   // Transfer size
  input  logic                   io_trans_i,  // Transaction valid
  input  logic [31:0]            io_wdata_i,  // Write data
  output logic [31:0]            io_rdata_o,  // Read data, same cycle

  // --------------------------------------------------
  // Pads, 32 bits per port, port 0 in the low word
  // --------------------------------------------------
  input  logic [NUM_PORTS*32-1:0] gpio_in_i,
  output logic [NUM_PORTS*32-1:0] gpio_out_o,
  output logic [NUM_PORTS*32-1:0] gpio_en_o,
  output logic [NUM_PORTS-1:0]    gpio_int_o   // One change pulse per port
);

  // One bus leg per port
  iop_bus_if legs [NUM_PORTS] ();

  iop_decoder #(
    .NUM_PORTS (NUM_PORTS)
  ) u_decoder (
    .io_sel_i   (io_sel_i),
    .io_addr_i  (io_addr_i),
    .io_write_i (io_write_i),
    .io_size_i  (io_size_i),
    .io_trans_i (io_trans_i),
    .io_wdata_i (io_wdata_i),
    .io_rdata_o (io_rdata_o),
    .legs       (legs)
  );

  // Each port takes its own 32-bit slice of the pad vectors
  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : g_port
    gpio_port u_port (
      .FCLK       (FCLK),
      .HRESETn    (HRESETn),
      .bus        (legs[i]),
      .gpio_in_i  (gpio_in_i[i*32 +: 32]),
      .gpio_out_o (gpio_out_o[i*32 +: 32]),
      .gpio_en_o  (gpio_en_o[i*32 +: 32]),
      .gpio_int_o (gpio_int_o[i])
    );
  end

endmodule

/* source/iop_bus_if.sv */
/* I/O port bus leg
   One decoded branch of the single-cycle bus, from decoder to one GPIO port */
`timescale 1ns/10ps

interface iop_bus_if;

  // --------------------------------------------------
  // Request side, driven by the decoder
  // --------------------------------------------------
  logic              sel;    // Port selected this cycle
  logic [31:0]       addr;   // Full transfer address
  logic              write;  // 1 for write, 0 for read
  iop_pkg::io_size_e size;   // Byte, half-word or word
  logic              trans;  // Transaction valid
  logic [31:0]       wdata;  // Write data

  // Response side, driven by the port
  logic [31:0]       rdata;  // Combinational read data

  // Decoder end
  modport master (
    output sel,
    output addr,
    output write,
    output size,
    output trans,
    output wdata,
    input  rdata
  );

  // Port end
  modport slave (
    input  sel,
    input  addr,
    input  write,
    input  size,
    input  trans,
    input  wdata,
    output rdata
  );

endinterface

/* source/iop_decoder.sv */
/* I/O port address decoder
   Steers each access to one GPIO port and returns that port's read data */
`timescale 1ns/10ps

module iop_decoder #(
  parameter int NUM_PORTS = 2
) (
  input  logic              io_sel_i,     // Bus select for this subsystem
  input  logic [31:0]       io_addr_i,    // Transfer address
  input  logic              io_write_i,   // Transfer direction
  input  iop_pkg::io_size_e io_size_i,    // Transfer size
  input  logic              io_trans_i,   // Transaction valid
  input  logic [31:0]       io_wdata_i,   // Write data
  output logic [31:0]       io_rdata_o,   // Read data of the selected port
  iop_bus_if.master         legs [NUM_PORTS]
);

  // Width of the port index field above the port span
  localparam int IDX_W = 32 - iop_pkg::PORT_SPAN_BITS;

  logic [IDX_W-1:0]     port_idx;             // Upper address bits
  logic [NUM_PORTS-1:0] leg_sel;              // One-hot select, or none
  logic [31:0]          leg_rdata [NUM_PORTS]; // Read data gathered from the legs

  assign port_idx = io_addr_i[31:iop_pkg::PORT_SPAN_BITS];

  // --------------------------------------------------
  // Per-leg fan-out
  // --------------------------------------------------

  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : g_leg
    // Only the leg whose index matches, and only while selected
    assign leg_sel[i] = io_sel_i & (port_idx == IDX_W'(i));

    assign legs[i].sel   = leg_sel[i];
    assign legs[i].addr  = io_addr_i;   // Shared fields pass through
    assign legs[i].write = io_write_i;
    assign legs[i].size  = io_size_i;
    assign legs[i].trans = io_trans_i;
    assign legs[i].wdata = io_wdata_i;

    assign leg_rdata[i] = legs[i].rdata;
  end

  // --------------------------------------------------
  // Read data return
  // --------------------------------------------------

  // Index at or above NUM_PORTS matches no leg and reads zero
  always_comb
  begin
    io_rdata_o = '0;
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      if (leg_sel[i])
        io_rdata_o = leg_rdata[i];  // At most one leg is selected
    end
  end

endmodule

/* source/iop_pkg.sv */
/* I/O port bus package
   Transfer size and GPIO register select encodings, register offsets and port span */
package iop_pkg;

  // --------------------------------------------------
  // Bus transfer size
  // --------------------------------------------------

  // Two bits wide, same coding as the bus size field
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,  // 8-bit access
    SIZE_HALF = 2'b01,  // 16-bit access
    SIZE_WORD = 2'b10   // 32-bit access
  } io_size_e;

  // --------------------------------------------------
  // GPIO register targets
  // --------------------------------------------------

  typedef enum logic [1:0] {
    REG_DATA    = 2'd0,  // Data out on write, sampled pins on read
    REG_DIR     = 2'd1,  // Direction, 1 drives the pin
    REG_INTMASK = 2'd2,  // Change interrupt enables
    REG_NONE    = 2'd3   // Unmapped offset
  } gpio_reg_e;

  // Word-group offsets in address bits 10:4
  localparam logic [6:0] DIR_OFFSET     = 7'h40;  // 0x400
  localparam logic [6:0] INTMASK_OFFSET = 7'h41;  // 0x410

  // Address bits decoded inside one port
  // Bits from here upward pick the port
  localparam int PORT_SPAN_BITS = 11;

endpackage
